// ==== car_defs.svh ====
`ifndef CAR_DEFS_SVH
`define CAR_DEFS_SVH

// Run/stop button filter length in samples
`define CAR_DEBOUNCE_TAPS 5

// Motor PWM
`define CAR_PWM_PERIOD 16
`define CAR_PWM_W 5

// Duty values are high cycles per PWM period
`define CAR_DUTY_FAST (`CAR_PWM_W'(12))
`define CAR_DUTY_SLOW (`CAR_PWM_W'(6))

// Ultrasonic ranger, all in clock cycles
`define CAR_SONIC_PERIOD 400
`define CAR_TRIG_CYCLES 10
// Echo narrower than this means something is close
`define CAR_STOP_WIDTH 120
`define CAR_SONIC_W 9

`endif

// ==== car_pkg.sv ====
package car_pkg;

  // Wheel direction code as the motor driver pins expect it
  typedef enum logic [1:0] {
    MOTOR_STOP     = 2'b00,
    MOTOR_FORWARD  = 2'b10,
    MOTOR_BACKWARD = 2'b01
  } motor_dir_e;

  // Where the line sits under the sensor bar
  typedef enum logic [1:0] {
    TRACK_CENTER,
    TRACK_LEFT,
    TRACK_RIGHT,
    TRACK_LOST
  } track_e;

  // Steering FSM states
  typedef enum logic [2:0] {
    DRIVE_IDLE,
    DRIVE_FORWARD,
    DRIVE_TURN_LEFT,
    DRIVE_TURN_RIGHT,
    DRIVE_SEARCH,
    DRIVE_BLOCKED
  } drive_e;

endpackage

// ==== button_pulse.sv ====
`timescale 1ns/1ps
`include "car_defs.svh"

module button_pulse (
  input  logic clk,
  input  logic rst_op,
  input  logic run_btn,
  output logic press
);

  logic [`CAR_DEBOUNCE_TAPS-1:0] samples;
  logic                          level;
  logic                          level_d;

  // Button counts as pressed only once every tap is high
  assign level = &samples;

  always_ff @(posedge clk) begin
    if (rst_op) begin
      samples <= '0;
      level_d <= 1'b0;
      press   <= 1'b0;
    end else begin
      samples <= {samples[`CAR_DEBOUNCE_TAPS-2:0], run_btn};
      level_d <= level;
      // Rising edge of the filtered level
      press   <= level & ~level_d;
    end
  end

endmodule

// ==== line_sensor_sync.sv ====
`timescale 1ns/1ps

module line_sensor_sync (
  input  logic            clk,
  input  logic            rst_op,
  input  logic            left_signal,
  input  logic            mid_signal,
  input  logic            right_signal,
  output car_pkg::track_e track
);

  // Bit order is left, mid, right
  logic [2:0] sync_1;
  logic [2:0] sync_2;

  always_ff @(posedge clk) begin
    if (rst_op) begin
      sync_1 <= 3'b000;
      sync_2 <= 3'b000;
    end else begin
      sync_1 <= {left_signal, mid_signal, right_signal};
      sync_2 <= sync_1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_op) begin
      track <= car_pkg::TRACK_LOST;
    end else begin
      if (sync_2 == 3'b000) begin
        track <= car_pkg::TRACK_LOST;
      end else if (sync_2[2] && !sync_2[0]) begin
        track <= car_pkg::TRACK_LEFT;
      end else if (sync_2[0] && !sync_2[2]) begin
        track <= car_pkg::TRACK_RIGHT;
      end else begin
        // Mid alone, or both outer sensors on a wide line
        track <= car_pkg::TRACK_CENTER;
      end
    end
  end

endmodule

// ==== sonic_ranger.sv ====
`timescale 1ns/1ps
`include "car_defs.svh"

module sonic_ranger (
  input  logic clk,
  input  logic rst_op,
  input  logic echo,
  output logic trig,
  output logic obstacle
);

  logic [`CAR_SONIC_W-1:0] round_cnt;
  logic [`CAR_SONIC_W-1:0] round_nxt;
  logic                    round_wrap;
  logic [`CAR_SONIC_W-1:0] width;
  logic                    echo_s1;
  logic                    echo_s2;
  logic                    echo_fall;
  logic                    echo_seen;

  assign round_wrap = (round_cnt == `CAR_SONIC_W'(`CAR_SONIC_PERIOD - 1));
  assign round_nxt  = round_wrap ? '0 : round_cnt + 1'b1;

  // Counter starts at the last count so the first round opens with a full trigger
  always_ff @(posedge clk) begin
    if (rst_op) begin
      round_cnt <= `CAR_SONIC_W'(`CAR_SONIC_PERIOD - 1);
      trig      <= 1'b0;
    end else begin
      round_cnt <= round_nxt;
      trig      <= (round_nxt < `CAR_SONIC_W'(`CAR_TRIG_CYCLES));
    end
  end

  always_ff @(posedge clk) begin
    if (rst_op) begin
      echo_s1 <= 1'b0;
      echo_s2 <= 1'b0;
    end else begin
      echo_s1 <= echo;
      echo_s2 <= echo_s1;
    end
  end

  assign echo_fall = echo_s2 & ~echo_s1;

  always_ff @(posedge clk) begin
    if (rst_op) begin
      width     <= '0;
      obstacle  <= 1'b0;
      echo_seen <= 1'b0;
    end else begin
      if (echo_fall) begin
        obstacle  <= (width < `CAR_SONIC_W'(`CAR_STOP_WIDTH));
        width     <= '0;
        echo_seen <= 1'b1;
      end else if (echo_s1 && !trig && width != '1) begin
        width <= width + 1'b1;
      end
      // Quiet round means nothing in range
      if (round_wrap) begin
        if (!echo_seen && !echo_s1 && !echo_fall) begin
          obstacle <= 1'b0;
        end
        echo_seen <= echo_s1;
      end
    end
  end

endmodule

// ==== drive_ctrl.sv ====
`timescale 1ns/1ps
`include "car_defs.svh"

module drive_ctrl (
  input  logic                  clk,
  input  logic                  rst_op,
  input  logic                  press,
  input  logic                  obstacle,
  input  car_pkg::track_e       track,
  output logic                  running,
  output car_pkg::motor_dir_e   left_dir,
  output car_pkg::motor_dir_e   right_dir,
  output logic [`CAR_PWM_W-1:0] left_duty,
  output logic [`CAR_PWM_W-1:0] right_duty
);

  car_pkg::drive_e state;
  car_pkg::drive_e state_nxt;
  logic            run_nxt;

  assign running = (state != car_pkg::DRIVE_IDLE);
  // Each press flips run/stop
  assign run_nxt = running ^ press;

  always_comb begin
    if (!run_nxt) begin
      state_nxt = car_pkg::DRIVE_IDLE;
    end else if (obstacle) begin
      state_nxt = car_pkg::DRIVE_BLOCKED;
    end else begin
      case (track)
        car_pkg::TRACK_CENTER: state_nxt = car_pkg::DRIVE_FORWARD;
        car_pkg::TRACK_LEFT:   state_nxt = car_pkg::DRIVE_TURN_LEFT;
        car_pkg::TRACK_RIGHT:  state_nxt = car_pkg::DRIVE_TURN_RIGHT;
        default:               state_nxt = car_pkg::DRIVE_SEARCH;
      endcase
    end
  end

  // Outputs decode the next state so wheels follow the inputs in one edge
  always_ff @(posedge clk) begin
    if (rst_op) begin
      state      <= car_pkg::DRIVE_IDLE;
      left_dir   <= car_pkg::MOTOR_STOP;
      right_dir  <= car_pkg::MOTOR_STOP;
      left_duty  <= '0;
      right_duty <= '0;
    end else begin
      state <= state_nxt;
      case (state_nxt)
        car_pkg::DRIVE_FORWARD: begin
          left_dir   <= car_pkg::MOTOR_FORWARD;
          right_dir  <= car_pkg::MOTOR_FORWARD;
          left_duty  <= `CAR_DUTY_FAST;
          right_duty <= `CAR_DUTY_FAST;
        end
        car_pkg::DRIVE_TURN_LEFT: begin
          left_dir   <= car_pkg::MOTOR_BACKWARD;
          right_dir  <= car_pkg::MOTOR_FORWARD;
          left_duty  <= `CAR_DUTY_SLOW;
          right_duty <= `CAR_DUTY_FAST;
        end
        car_pkg::DRIVE_TURN_RIGHT: begin
          left_dir   <= car_pkg::MOTOR_FORWARD;
          right_dir  <= car_pkg::MOTOR_BACKWARD;
          left_duty  <= `CAR_DUTY_FAST;
          right_duty <= `CAR_DUTY_SLOW;
        end
        car_pkg::DRIVE_SEARCH: begin
          left_dir   <= car_pkg::MOTOR_BACKWARD;
          right_dir  <= car_pkg::MOTOR_BACKWARD;
          left_duty  <= `CAR_DUTY_SLOW;
          right_duty <= `CAR_DUTY_SLOW;
        end
        default: begin
          // Idle and blocked both hold the car still
          left_dir   <= car_pkg::MOTOR_STOP;
          right_dir  <= car_pkg::MOTOR_STOP;
          left_duty  <= '0;
          right_duty <= '0;
        end
      endcase
    end
  end

endmodule

// ==== motor_pwm.sv ====
`timescale 1ns/1ps
`include "car_defs.svh"

module motor_pwm (
  input  logic                  clk,
  input  logic                  rst_op,
  input  car_pkg::motor_dir_e   left_dir,
  input  car_pkg::motor_dir_e   right_dir,
  input  logic [`CAR_PWM_W-1:0] left_duty,
  input  logic [`CAR_PWM_W-1:0] right_duty,
  output logic                  left_pwm,
  output logic                  right_pwm,
  output car_pkg::motor_dir_e   left,
  output car_pkg::motor_dir_e   right
);

  logic [`CAR_PWM_W-1:0] pwm_cnt;

  // One period counter shared by both wheels
  always_ff @(posedge clk) begin
    if (rst_op) begin
      pwm_cnt <= '0;
    end else if (pwm_cnt == `CAR_PWM_W'(`CAR_PWM_PERIOD - 1)) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  // Speed and direction pins are registered on the same edge
  always_ff @(posedge clk) begin
    if (rst_op) begin
      left_pwm  <= 1'b0;
      right_pwm <= 1'b0;
      left      <= car_pkg::MOTOR_STOP;
      right     <= car_pkg::MOTOR_STOP;
    end else begin
      left_pwm  <= (pwm_cnt < left_duty);
      right_pwm <= (pwm_cnt < right_duty);
      left      <= left_dir;
      right     <= right_dir;
    end
  end

endmodule

// ==== car_top.sv ====
`timescale 1ns/1ps
`include "car_defs.svh"

module car_top (
  input  logic                clk,
  input  logic                rst_op,
  input  logic                run_btn,
  input  logic                echo,
  input  logic                left_signal,
  input  logic                mid_signal,
  input  logic                right_signal,
  output logic                trig,
  output logic                obstacle,
  output logic                running,
  output logic                left_pwm,
  output logic                right_pwm,
  output car_pkg::motor_dir_e left,
  output car_pkg::motor_dir_e right
);

  logic                  press;
  car_pkg::track_e       track;
  car_pkg::motor_dir_e   left_dir;
  car_pkg::motor_dir_e   right_dir;
  logic [`CAR_PWM_W-1:0] left_duty;
  logic [`CAR_PWM_W-1:0] right_duty;

  button_pulse btn_i (
    .clk     (clk),
    .rst_op  (rst_op),
    .run_btn (run_btn),
    .press   (press)
  );

  line_sensor_sync line_i (
    .clk          (clk),
    .rst_op       (rst_op),
    .left_signal  (left_signal),
    .mid_signal   (mid_signal),
    .right_signal (right_signal),
    .track        (track)
  );

  sonic_ranger sonic_i (
    .clk      (clk),
    .rst_op   (rst_op),
    .echo     (echo),
    .trig     (trig),
    .obstacle (obstacle)
  );

  drive_ctrl ctrl_i (
    .clk        (clk),
    .rst_op     (rst_op),
    .press      (press),
    .obstacle   (obstacle),
    .track      (track),
    .running    (running),
    .left_dir   (left_dir),
    .right_dir  (right_dir),
    .left_duty  (left_duty),
    .right_duty (right_duty)
  );

  // Output stage adds one edge to every wheel pin
  motor_pwm pwm_i (
    .clk        (clk),
    .rst_op     (rst_op),
    .left_dir   (left_dir),
    .right_dir  (right_dir),
    .left_duty  (left_duty),
    .right_duty (right_duty),
    .left_pwm   (left_pwm),
    .right_pwm  (right_pwm),
    .left       (left),
    .right      (right)
  );

endmodule

// ==== tb_car.sv ====
`timescale 1ns/1ps
`include "car_defs.svh"

module tb_car;

  // One sonic round for the trigger test, up to four for the obstacle test,
  // the rest covers button, line and PWM tests with margin
  localparam int TIMEOUT_CYCLES = 5 * `CAR_SONIC_PERIOD + 1000;
  localparam int N_PATTERNS = 24;

  logic clk;
  logic rst_op;
  logic run_btn;
  logic echo;
  logic left_signal, mid_signal, right_signal;
  logic trig, obstacle, running;
  logic left_pwm, right_pwm;
  car_pkg::motor_dir_e left, right;

  int errors = 0;
  int tests = 0;
  int failed = 0;
  int cycles = 0;
  int seed = 76;
  logic trig_last = 1'b0;

  car_top dut_i (
    .clk(clk), .rst_op(rst_op), .run_btn(run_btn), .echo(echo),
    .left_signal(left_signal), .mid_signal(mid_signal), .right_signal(right_signal),
    .trig(trig), .obstacle(obstacle), .running(running),
    .left_pwm(left_pwm), .right_pwm(right_pwm), .left(left), .right(right)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  assert property (@(posedge clk) $fell(rst_op) |-> (!trig && !obstacle && !running &&
    !left_pwm && !right_pwm && left == car_pkg::MOTOR_STOP && right == car_pkg::MOTOR_STOP))
    else begin
      $display("outputs were not at their reset values on the edge after reset");
      errors++;
    end

  // A stopped wheel never gets drive pulses
  assert property (@(posedge clk) disable iff (rst_op)
    (left == car_pkg::MOTOR_STOP) |-> !left_pwm)
    else begin
      $display("left_pwm high while the left wheel is stopped");
      errors++;
    end
  assert property (@(posedge clk) disable iff (rst_op)
    (right == car_pkg::MOTOR_STOP) |-> !right_pwm)
    else begin
      $display("right_pwm high while the right wheel is stopped");
      errors++;
    end

  task automatic tick();
    trig_last = trig;
    @(posedge clk);
    #1;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dir(input string name, input car_pkg::motor_dir_e got,
                           input car_pkg::motor_dir_e exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - start);
    end
  endtask

  // Bit order is left, mid, right
  task automatic set_sensors(input logic [2:0] s);
    left_signal = s[2];
    mid_signal = s[1];
    right_signal = s[0];
  endtask

  // Left wheel backs up when the line is lost or lies to the left only
  function automatic car_pkg::motor_dir_e expect_left(input logic [2:0] s);
    if (s == 3'b000 || s == 3'b100 || s == 3'b110) return car_pkg::MOTOR_BACKWARD;
    return car_pkg::MOTOR_FORWARD;
  endfunction

  function automatic car_pkg::motor_dir_e expect_right(input logic [2:0] s);
    if (s == 3'b000 || s == 3'b001 || s == 3'b011) return car_pkg::MOTOR_BACKWARD;
    return car_pkg::MOTOR_FORWARD;
  endfunction

  // Forward always runs fast, backward always slow
  function automatic int duty_of(input car_pkg::motor_dir_e dir);
    case (dir)
      car_pkg::MOTOR_FORWARD:  return int'(`CAR_DUTY_FAST);
      car_pkg::MOTOR_BACKWARD: return int'(`CAR_DUTY_SLOW);
      default:                 return 0;
    endcase
  endfunction

  task automatic check_reset_values();
    check_bit("trig", trig, 1'b0);
    check_bit("obstacle", obstacle, 1'b0);
    check_bit("running", running, 1'b0);
    check_bit("left_pwm", left_pwm, 1'b0);
    check_bit("right_pwm", right_pwm, 1'b0);
    check_dir("left", left, car_pkg::MOTOR_STOP);
    check_dir("right", right, car_pkg::MOTOR_STOP);
  endtask

  task automatic check_wheels(input car_pkg::motor_dir_e exp_l, input car_pkg::motor_dir_e exp_r);
    int lhi;
    int rhi;
    check_dir("left", left, exp_l);
    check_dir("right", right, exp_r);
    lhi = 0;
    rhi = 0;
    repeat (`CAR_PWM_PERIOD) begin
      if (left_pwm) lhi++;
      if (right_pwm) rhi++;
      tick();
    end
    check_count("left_pwm high cycles", lhi, duty_of(exp_l));
    check_count("right_pwm high cycles", rhi, duty_of(exp_r));
  endtask

  task automatic press_button(input logic want, input int hold);
    int waited;
    run_btn = 1'b1;
    waited = 0;
    while (running !== want && waited < `CAR_DEBOUNCE_TAPS + 3) begin
      tick();
      waited++;
    end
    assert (running === want) else begin
      $display("long press did not toggle running within %0d cycles", waited);
      errors++;
    end
    repeat (hold) begin
      tick();
      check_bit("running", running, want);
    end
    run_btn = 1'b0;
    repeat (`CAR_DEBOUNCE_TAPS + 2) tick();
    check_bit("running", running, want);
  endtask

  task automatic wait_trig_fall();
    while (!(trig_last && !trig)) tick();
  endtask

  // Echo pulse of the given width, then obstacle must settle within 3 cycles
  task automatic send_echo(input int width, input logic want);
    int waited;
    echo = 1'b1;
    repeat (width) tick();
    echo = 1'b0;
    waited = 0;
    while (obstacle !== want && waited < 3) begin
      tick();
      waited++;
    end
    assert (obstacle === want) else begin
      $display("obstacle did not follow an echo of %0d cycles", width);
      errors++;
    end
    repeat (2) tick();
  endtask

  initial begin
    int start;
    int pat;
    int hi;
    int per;
    int rises;
    logic [2:0] s;
    logic [2:0] pwm_pats [4];
    clk = 1'b0;
    rst_op = 1'b1;
    run_btn = 1'b0;
    echo = 1'b0;
    set_sensors(3'b000);
    pwm_pats = '{3'b010, 3'b100, 3'b001, 3'b000};

    start = errors;
    repeat (4) begin
      tick();
      check_reset_values();
    end
    rst_op = 1'b0;
    check_reset_values();
    tick();
    report("reset", start);

    start = errors;
    while (!(trig && !trig_last)) tick();
    hi = 1;
    per = 0;
    do begin
      tick();
      per++;
      if (trig && trig_last) hi++;
    end while (!(trig && !trig_last));
    check_count("trig high cycles", hi, `CAR_TRIG_CYCLES);
    check_count("trig period", per, `CAR_SONIC_PERIOD);
    report("trigger", start);

    start = errors;
    for (int len = 1; len < `CAR_DEBOUNCE_TAPS; len++) begin
      run_btn = 1'b1;
      repeat (len) tick();
      run_btn = 1'b0;
      repeat (`CAR_DEBOUNCE_TAPS + 4) tick();
      check_bit("running", running, 1'b0);
    end
    press_button(1'b1, 20);
    press_button(1'b0, 4);
    check_wheels(car_pkg::MOTOR_STOP, car_pkg::MOTOR_STOP);
    press_button(1'b1, 4);
    report("button", start);

    start = errors;
    for (int i = 0; i < N_PATTERNS; i++) begin
      pat = $random(seed);
      s = pat[2:0];
      set_sensors(s);
      repeat (8) tick();
      check_dir("left", left, expect_left(s));
      check_dir("right", right, expect_right(s));
    end
    report("steering", start);

    start = errors;
    for (int i = 0; i < 4; i++) begin
      set_sensors(pwm_pats[i]);
      repeat (8) tick();
      check_wheels(expect_left(pwm_pats[i]), expect_right(pwm_pats[i]));
    end
    report("pwm", start);

    start = errors;
    pat = $random(seed);
    s = pat[2:0];
    set_sensors(s);
    wait_trig_fall();
    send_echo(20 + ({$random(seed)} % 80), 1'b1);
    check_bit("running", running, 1'b1);
    check_wheels(car_pkg::MOTOR_STOP, car_pkg::MOTOR_STOP);
    wait_trig_fall();
    check_bit("obstacle", obstacle, 1'b1);
    send_echo(`CAR_STOP_WIDTH + 20 + ({$random(seed)} % 100), 1'b0);
    check_wheels(expect_left(s), expect_right(s));
    // Flag set once more holds over its own wrap and clears after a quiet round
    send_echo(20 + ({$random(seed)} % 80), 1'b1);
    rises = 0;
    while (rises < 2) begin
      tick();
      if (trig && !trig_last) rises++;
      check_bit("obstacle", obstacle, rises < 2);
    end
    report("obstacle", start);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
car_pkg.sv
button_pulse.sv
line_sensor_sync.sv
sonic_ranger.sv
drive_ctrl.sv
motor_pwm.sv
car_top.sv
tb_car.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the car controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_car -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi
./obj_dir/Vtb_car > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0
